//--- src.f
design/ppcPkg.sv
design/gprFile.sv
design/instrDecode.sv
design/execUnit.sv
design/resultStage.sv
design/ppcCore.sv
sim/clockGen.sv
sim/ppcCoreTb.sv

//--- sim/ppcCoreTb.sv
`default_nettype none

module ppcCoreTb;
	import ppcPkg::*;

	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 4;
	// roughly 60 issue slots over all tests
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 64 + 40;

	logic clk;
	logic rst_n;
	logic instrValid;
	instrWord_t instr;
	gprWrite_t wb;
	logic [31:0] crValue;

	gprData_t gprModel [GPR_COUNT];
	logic [31:0] crModel;
	gprWrite_t wbPipe [2];
	logic [31:0] crPipe [3];
	logic [15:0] lfsr = 16'd28791;

	clockGen #(.PERIOD(20)) i_clockGen (.clk(clk));

	ppcCore i_ppcCore (
		.clk(clk),
		.rst_n(rst_n),
		.instrValid(instrValid),
		.instr(instr),
		.wb(wb),
		.crValue(crValue)
	);

	task automatic stopWithFailure();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// galois lfsr, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic outBit;
		v = '0;
		for (int i = 0; i < n; i++) begin
			outBit = lfsr[0];
			lfsr = lfsr >> 1;
			if (outBit) lfsr = lfsr ^ 16'hB400;
			v = {v[30:0], outBit};
		end
		return v;
	endfunction

	function automatic instrWord_t dForm(input logic [5:0] opcd, input regIdx_t rt,
			input regIdx_t ra, input logic [15:0] imm);
		return {opcd, rt, ra, imm};
	endfunction

	function automatic instrWord_t xForm(input regIdx_t rt, input regIdx_t ra,
			input regIdx_t rb, input logic [9:0] xo);
		return {OPCD_XGROUP, rt, ra, rb, xo, 1'b0};
	endfunction

	function automatic crBits_t compareBits(input gprData_t a, input gprData_t b,
			input logic signedCmp);
		crBits_t c;
		c = '0;
		if (signedCmp) begin
			c.lt = $signed(a) < $signed(b);
			c.gt = $signed(a) > $signed(b);
		end else begin
			c.lt = a < b;
			c.gt = a > b;
		end
		c.eq = a == b;
		return c;
	endfunction

	task automatic checkWb(input gprWrite_t got, input gprWrite_t exp);
		if (got.en !== exp.en || (exp.en && (got.idx !== exp.idx || got.data !== exp.data))) begin
			$display("ERR t=%0t wb got en=%0b idx=%0d data=%h expected en=%0b idx=%0d data=%h",
				$time, got.en, got.idx, got.data, exp.en, exp.idx, exp.data);
			stopWithFailure();
		end
	endtask

	task automatic checkCr(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t crValue got %h expected %h", $time, got, exp);
			stopWithFailure();
		end
	endtask

	// reference model, updated in issue order
	task automatic modelInstr(input logic v, input instrWord_t w, output gprWrite_t e);
		regIdx_t rt;
		regIdx_t ra;
		regIdx_t rb;
		gprData_t s16;
		gprData_t u16;
		gprData_t r;
		crBits_t c;
		logic doCr;
		crField_t f;
		rt = w[25:21];
		ra = w[20:16];
		rb = w[15:11];
		s16 = {{16{w[15]}}, w[15:0]};
		u16 = {16'h0000, w[15:0]};
		f = w[25:23];
		e = '0;
		c = '0;
		doCr = 1'b0;
		if (v) begin
			case (w[31:26])
				OPCD_ADDI: e = '{1'b1, rt, (ra == 0 ? 32'h0 : gprModel[ra]) + s16};
				OPCD_ADDIS: e = '{1'b1, rt, (ra == 0 ? 32'h0 : gprModel[ra]) + {w[15:0], 16'h0}};
				OPCD_ORI: e = '{1'b1, ra, gprModel[rt] | u16};
				OPCD_ANDI: begin
					r = gprModel[rt] & u16;
					e = '{1'b1, ra, r};
					c = compareBits(r, 32'h0, 1'b1);
					f = 3'd0;
					doCr = 1'b1;
				end
				OPCD_CMPWI: {c, doCr} = {compareBits(gprModel[ra], s16, 1'b1), 1'b1};
				OPCD_CMPLWI: {c, doCr} = {compareBits(gprModel[ra], u16, 1'b0), 1'b1};
				OPCD_XGROUP: begin
					case (w[10:1])
						XO_ADD: e = '{1'b1, rt, gprModel[ra] + gprModel[rb]};
						XO_SUBF: e = '{1'b1, rt, gprModel[rb] - gprModel[ra]};
						XO_AND: e = '{1'b1, ra, gprModel[rt] & gprModel[rb]};
						XO_OR: e = '{1'b1, ra, gprModel[rt] | gprModel[rb]};
						XO_XOR: e = '{1'b1, ra, gprModel[rt] ^ gprModel[rb]};
						XO_CMP: {c, doCr} = {compareBits(gprModel[ra], gprModel[rb], 1'b1), 1'b1};
						default: ;
					endcase
				end
				default: ;
			endcase
		end
		if (e.en) gprModel[e.idx] = e.data;
		if (doCr) crModel[31 - 4 * f -: 4] = c;
	endtask

	// one issue slot: check what is due now, then drive the next word
	task automatic step(input logic v, input instrWord_t w);
		gprWrite_t expWb;
		@(posedge clk);
		#DRIVE_DELAY;
		checkWb(wb, wbPipe[1]);
		checkCr(crValue, crPipe[2]);
		modelInstr(v, w, expWb);
		wbPipe[1] = wbPipe[0];
		wbPipe[0] = expWb;
		crPipe[2] = crPipe[1];
		crPipe[1] = crPipe[0];
		crPipe[0] = crModel;
		instrValid = v;
		instr = w;
	endtask

	task automatic issue(input instrWord_t w);
		step(1'b1, w);
	endtask

	task automatic drain();
		repeat (3) step(1'b0, randBits(32));
	endtask

	task automatic loadReg(input regIdx_t idx, input gprData_t value);
		issue(dForm(OPCD_ADDIS, idx, 5'd0, value[31:16]));
		issue(dForm(OPCD_ORI, idx, idx, value[15:0]));
	endtask

	task automatic testReset();
		drain();
	endtask

	task automatic testImmediates();
		// make r0 nonzero so the literal zero of rA shows
		issue(dForm(OPCD_ADDI, 5'd0, 5'd0, 16'h1234));
		issue(dForm(OPCD_ADDI, 5'd1, 5'd0, randBits(16)));
		issue(dForm(OPCD_ADDI, 5'd2, 5'd1, 16'hFFEC));
		issue(dForm(OPCD_ADDIS, 5'd3, 5'd0, randBits(16)));
		issue(dForm(OPCD_ORI, 5'd4, 5'd3, randBits(16)));
		drain();
	endtask

	task automatic testRegOps();
		for (int i = 1; i <= 6; i++) begin
			loadReg(i, randBits(32));
		end
		issue(xForm(5'd7, 5'd1, 5'd2, XO_ADD));
		issue(xForm(5'd8, 5'd3, 5'd4, XO_SUBF));
		issue(xForm(5'd5, 5'd9, 5'd6, XO_AND));
		issue(xForm(5'd1, 5'd10, 5'd4, XO_OR));
		issue(xForm(5'd2, 5'd11, 5'd3, XO_XOR));
		drain();
	endtask

	task automatic testForwarding();
		issue(dForm(OPCD_ADDI, 5'd10, 5'd0, 16'd5));
		issue(dForm(OPCD_ADDI, 5'd10, 5'd10, 16'd7));
		issue(dForm(OPCD_ADDI, 5'd11, 5'd0, 16'hFFFD));
		issue(xForm(5'd12, 5'd10, 5'd11, XO_ADD));
		issue(xForm(5'd13, 5'd10, 5'd12, XO_SUBF));
		issue(xForm(5'd12, 5'd14, 5'd13, XO_XOR));
		step(1'b0, '0);
		issue(xForm(5'd15, 5'd14, 5'd13, XO_ADD));
		// r0 written, then read as a literal zero
		issue(xForm(5'd0, 5'd1, 5'd2, XO_ADD));
		issue(dForm(OPCD_ADDI, 5'd16, 5'd0, 16'd9));
		drain();
	endtask

	task automatic testCompares();
		issue(xForm({3'd1, 2'b00}, 5'd1, 5'd2, XO_CMP));
		issue(dForm(OPCD_CMPWI, {3'd3, 2'b00}, 5'd3, 16'hFFFF));
		issue(dForm(OPCD_CMPLWI, {3'd5, 2'b00}, 5'd3, 16'hFFFF));
		issue(dForm(OPCD_ANDI, 5'd1, 5'd17, 16'h8001));
		issue(dForm(OPCD_ANDI, 5'd1, 5'd18, 16'h0000));
		drain();
	endtask

	task automatic testUnsupported();
		issue({6'd7, 26'(randBits(26))});
		issue(xForm(5'd3, 5'd4, 5'd5, 10'd999));
		drain();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before the tests finished");
		stopWithFailure();
	end

	initial begin
		rst_n = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		crModel = '0;
		for (int i = 0; i < GPR_COUNT; i++) begin
			gprModel[i] = '0;
		end
		wbPipe[0] = '0;
		wbPipe[1] = '0;
		crPipe[0] = '0;
		crPipe[1] = '0;
		crPipe[2] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		testReset();
		testImmediates();
		testRegOps();
		testForwarding();
		testCompares();
		testUnsupported();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/clockGen.sv
`default_nettype none

module clockGen #(
	parameter int PERIOD = 20
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- design/ppcCore.sv
`default_nettype none

module ppcCore (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instrValid,
	input wire ppcPkg::instrWord_t instr,
	output ppcPkg::gprWrite_t wb,
	output logic [ppcPkg::CR_FIELDS*ppcPkg::CR_FIELD_W-1:0] crValue
);
	import ppcPkg::*;

	regIdx_t raIdx;
	regIdx_t rbIdx;
	gprData_t aVal;
	gprData_t bVal;
	decodeBundle_t bundle;
	execResult_t result;

	gprFile i_gprFile (
		.clk(clk),
		.rst_n(rst_n),
		.raIdx(raIdx),
		.rbIdx(rbIdx),
		.aVal(aVal),
		.bVal(bVal),
		.wr(wb)
	);

	instrDecode i_instrDecode (
		.clk(clk),
		.rst_n(rst_n),
		.instrValid(instrValid),
		.instr(instr),
		.raIdx(raIdx),
		.rbIdx(rbIdx),
		.aVal(aVal),
		.bVal(bVal),
		.bundle(bundle)
	);

	execUnit i_execUnit (
		.clk(clk),
		.rst_n(rst_n),
		.bundle(bundle),
		.result(result)
	);

	// its write port also feeds the register file
	resultStage i_resultStage (
		.clk(clk),
		.rst_n(rst_n),
		.result(result),
		.wr(wb),
		.crValue(crValue)
	);

endmodule

`default_nettype wire

//--- design/resultStage.sv
`default_nettype none

module resultStage (
	input wire logic clk,
	input wire logic rst_n,
	input wire ppcPkg::execResult_t result,
	output ppcPkg::gprWrite_t wr,
	output logic [ppcPkg::CR_FIELDS*ppcPkg::CR_FIELD_W-1:0] crValue
);
	import ppcPkg::*;

	int unsigned fieldLsb;

	assign wr = '{
		en: result.writesGpr,
		idx: result.rd,
		data: result.data
	};

	// field 0 sits at the top of the register
	assign fieldLsb = (CR_FIELDS - 1 - int'(result.crField)) * CR_FIELD_W;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crValue <= '0;
		end else if (result.setsCr) begin
			crValue[fieldLsb +: CR_FIELD_W] <= result.crBits;
		end
	end

	crOnlyOnSet: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(crValue) |-> $past(result.setsCr));

endmodule

`default_nettype wire

//--- design/execUnit.sv
`default_nettype none

module execUnit (
	input wire logic clk,
	input wire logic rst_n,
	input wire ppcPkg::decodeBundle_t bundle,
	output ppcPkg::execResult_t result
);
	import ppcPkg::*;

	logic aLiteral;
	logic fwdA;
	logic fwdB;
	gprData_t opA;
	gprData_t regB;
	gprData_t opB;
	gprData_t aluOut;
	crBits_t cmpBits;
	execResult_t nextResult;

	// a literal zero A operand must not pick up a result for r0
	assign aLiteral = bundle.op == ADD && bundle.useImm && bundle.ra == '0;

	// one ahead comes from our own result register
	assign fwdA = result.writesGpr && result.rd == bundle.ra && !aLiteral;
	assign fwdB = result.writesGpr && result.rd == bundle.rb;

	assign opA = fwdA ? result.data : bundle.aVal;
	assign regB = fwdB ? result.data : bundle.bVal;
	assign opB = bundle.useImm ? bundle.imm : regB;

	always_comb begin
		aluOut = '0;
		cmpBits = '0;
		case (bundle.op)
			ADD: aluOut = opA + opB;
			SUBF: aluOut = opB - opA;
			AND: aluOut = opA & opB;
			OR: aluOut = opA | opB;
			XOR: aluOut = opA ^ opB;
			CMPS: begin
				cmpBits.lt = $signed(opA) < $signed(opB);
				cmpBits.gt = $signed(opA) > $signed(opB);
				cmpBits.eq = opA == opB;
			end
			CMPU: begin
				cmpBits.lt = opA < opB;
				cmpBits.gt = opA > opB;
				cmpBits.eq = opA == opB;
			end
			default: ;
		endcase
		// andi. records its result against zero, signed
		if (bundle.op == AND && bundle.setsCr) begin
			cmpBits.lt = aluOut[DATA_W-1];
			cmpBits.gt = !aluOut[DATA_W-1] && aluOut != '0;
			cmpBits.eq = aluOut == '0;
		end
	end

	assign nextResult = '{
		writesGpr: bundle.writesGpr,
		rd: bundle.rd,
		data: aluOut,
		setsCr: bundle.setsCr,
		crField: bundle.crField,
		crBits: cmpBits
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else begin
			result <= nextResult;
		end
	end

	cmpNoGprWrite: assert property (@(posedge clk) disable iff (!rst_n)
		bundle.valid && bundle.op inside {CMPS, CMPU}
		|=> result.setsCr && !result.writesGpr);

endmodule

`default_nettype wire

//--- design/instrDecode.sv
`default_nettype none

module instrDecode (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instrValid,
	input wire ppcPkg::instrWord_t instr,
	output ppcPkg::regIdx_t raIdx,
	output ppcPkg::regIdx_t rbIdx,
	input wire ppcPkg::gprData_t aVal,
	input wire ppcPkg::gprData_t bVal,
	output ppcPkg::decodeBundle_t bundle
);
	import ppcPkg::*;

	logic [5:0] opcd;
	logic [9:0] xo;
	logic [15:0] imm16;
	regIdx_t rtField;
	regIdx_t raField;
	regIdx_t rbField;
	crField_t bf;
	gprData_t immS;
	gprData_t immU;
	logic aLiteral;
	decodeBundle_t ctl;
	decodeBundle_t nextBundle;

	// big-endian bit 0 is instr[31]
	assign opcd = instr[31:26];
	assign rtField = instr[25:21];
	assign raField = instr[20:16];
	assign rbField = instr[15:11];
	assign bf = instr[25:23];
	assign imm16 = instr[15:0];
	assign xo = instr[10:1];

	assign immS = {{16{imm16[15]}}, imm16};
	assign immU = {16'h0000, imm16};

	// addi/addis with rA = 0 take a literal zero
	assign aLiteral = (opcd == OPCD_ADDI || opcd == OPCD_ADDIS) && raField == '0;

	always_comb begin
		ctl = '0;
		ctl.op = NONE;
		ctl.rd = rtField;
		ctl.ra = raField;
		ctl.rb = rbField;
		ctl.crField = bf;
		case (opcd)
			OPCD_ADDI, OPCD_ADDIS: begin
				ctl.op = ADD;
				ctl.useImm = 1'b1;
				ctl.imm = (opcd == OPCD_ADDIS) ? {imm16, 16'h0000} : immS;
				ctl.writesGpr = 1'b1;
			end
			OPCD_ORI, OPCD_ANDI: begin
				// logical forms write rA from rS
				ctl.op = (opcd == OPCD_ORI) ? OR : AND;
				ctl.rd = raField;
				ctl.ra = rtField;
				ctl.useImm = 1'b1;
				ctl.imm = immU;
				ctl.writesGpr = 1'b1;
				ctl.setsCr = (opcd == OPCD_ANDI);
				ctl.crField = '0;
			end
			OPCD_CMPWI, OPCD_CMPLWI: begin
				ctl.op = (opcd == OPCD_CMPWI) ? CMPS : CMPU;
				ctl.useImm = 1'b1;
				ctl.imm = (opcd == OPCD_CMPWI) ? immS : immU;
				ctl.setsCr = 1'b1;
			end
			OPCD_XGROUP: begin
				case (xo)
					XO_ADD: begin
						ctl.op = ADD;
						ctl.writesGpr = 1'b1;
					end
					XO_SUBF: begin
						ctl.op = SUBF;
						ctl.writesGpr = 1'b1;
					end
					XO_AND, XO_OR, XO_XOR: begin
						ctl.op = (xo == XO_AND) ? AND : (xo == XO_OR) ? OR : XOR;
						ctl.rd = raField;
						ctl.ra = rtField;
						ctl.writesGpr = 1'b1;
					end
					XO_CMP: begin
						ctl.op = CMPS;
						ctl.setsCr = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
		ctl.valid = instrValid;
		ctl.writesGpr = ctl.writesGpr && instrValid;
		ctl.setsCr = ctl.setsCr && instrValid;
	end

	assign raIdx = ctl.ra;
	assign rbIdx = ctl.rb;

	always_comb begin
		nextBundle = ctl;
		nextBundle.aVal = aLiteral ? '0 : aVal;
		nextBundle.bVal = bVal;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bundle <= '0;
		end else begin
			bundle <= nextBundle;
		end
	end

	instrKnown: assert property (@(posedge clk) disable iff (!rst_n)
		instrValid |-> !$isunknown(instr));

endmodule

`default_nettype wire

//--- design/gprFile.sv
`default_nettype none

module gprFile (
	input wire logic clk,
	input wire logic rst_n,
	input wire ppcPkg::regIdx_t raIdx,
	input wire ppcPkg::regIdx_t rbIdx,
	output ppcPkg::gprData_t aVal,
	output ppcPkg::gprData_t bVal,
	input wire ppcPkg::gprWrite_t wr
);
	import ppcPkg::*;

	gprData_t regs [GPR_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < GPR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.idx] <= wr.data;
		end
	end

	// writeback in flight wins over the stored value
	assign aVal = (wr.en && wr.idx == raIdx) ? wr.data : regs[raIdx];
	assign bVal = (wr.en && wr.idx == rbIdx) ? wr.data : regs[rbIdx];

	wrIdxKnown: assert property (@(posedge clk) disable iff (!rst_n)
		wr.en |-> !$isunknown(wr.idx));

endmodule

`default_nettype wire

//--- design/ppcPkg.sv
`default_nettype none

package ppcPkg;

	localparam int GPR_COUNT = 32;
	localparam int REG_IDX_W = $clog2(GPR_COUNT);
	localparam int DATA_W = 32;
	localparam int CR_FIELD_W = 4;
	localparam int CR_FIELDS = 8;

	typedef logic [31:0] instrWord_t;
	typedef logic [REG_IDX_W-1:0] regIdx_t;
	typedef logic [DATA_W-1:0] gprData_t;
	typedef logic [$clog2(CR_FIELDS)-1:0] crField_t;

	// lt is the most significant bit of a field
	typedef struct packed {
		logic lt;
		logic gt;
		logic eq;
		logic so;
	} crBits_t;

	// primary opcodes, instruction bits 0..5
	localparam logic [5:0] OPCD_ADDI = 6'd14;
	localparam logic [5:0] OPCD_ADDIS = 6'd15;
	localparam logic [5:0] OPCD_ORI = 6'd24;
	localparam logic [5:0] OPCD_ANDI = 6'd28;
	localparam logic [5:0] OPCD_CMPWI = 6'd11;
	localparam logic [5:0] OPCD_CMPLWI = 6'd10;
	localparam logic [5:0] OPCD_XGROUP = 6'd31;

	// extended opcodes of the opcode-31 group
	localparam logic [9:0] XO_ADD = 10'd266;
	localparam logic [9:0] XO_SUBF = 10'd40;
	localparam logic [9:0] XO_AND = 10'd28;
	localparam logic [9:0] XO_OR = 10'd444;
	localparam logic [9:0] XO_XOR = 10'd316;
	localparam logic [9:0] XO_CMP = 10'd0;

	typedef enum logic [2:0] {ADD, SUBF, AND, OR, XOR, CMPS, CMPU, NONE} aluOp_e;

	typedef struct packed {
		logic valid;
		aluOp_e op;
		regIdx_t rd;
		regIdx_t ra;
		regIdx_t rb;
		gprData_t aVal;
		gprData_t bVal;
		logic useImm;
		gprData_t imm;
		logic writesGpr;
		logic setsCr;
		crField_t crField;
	} decodeBundle_t;

	typedef struct packed {
		logic writesGpr;
		regIdx_t rd;
		gprData_t data;
		logic setsCr;
		crField_t crField;
		crBits_t crBits;
	} execResult_t;

	typedef struct packed {
		logic en;
		regIdx_t idx;
		gprData_t data;
	} gprWrite_t;

endpackage

`default_nettype wire
